// File: source/pcs_pkg.sv
//************************************************************
// shared constants and types of the 10G transmit PCS slice
// one 64b/66b block per clock, no ordered sets or lane-4 starts
// terminate blocks carry zero instead of control codes in unused bytes
//************************************************************
`default_nettype none

package pcs_pkg;

	localparam int BLOCK_W = 64; // block payload, sync header excluded
	localparam int KEEP_W  = 8;
	localparam int TYPE_W  = 8;  // block type field in byte 0
	localparam int CTRL_W  = 7;

	localparam logic [CTRL_W-1:0] CTRL_IDLE = 7'h07;

	// sync headers
	localparam logic [1:0] SYNC_DATA = 2'b01;
	localparam logic [1:0] SYNC_CTRL = 2'b10;

	// six 0x55 bytes then the SFD, lowest byte first
	localparam logic [BLOCK_W-TYPE_W-1:0] PREAMBLE = 56'hd5_55_55_55_55_55_55;

	typedef enum logic [TYPE_W-1:0] {
		CTRL    = 8'h1e, // C7 .. C0
		START_0 = 8'h78, // D7 .. D1, preamble
		TERM_0  = 8'h87,
		TERM_1  = 8'h99,
		TERM_2  = 8'haa,
		TERM_3  = 8'hb4,
		TERM_4  = 8'hcc,
		TERM_5  = 8'hd2,
		TERM_6  = 8'he1,
		TERM_7  = 8'hff  // D6 .. D0
	} block_type_e;

	// onehot encoded
	typedef enum logic [2:0] {
		IDLE      = 3'b001,
		DATA      = 3'b010,
		END_DELAY = 3'b100 // terminate block still owed
	} enc_state_e;

	typedef enum logic [1:0] {
		GAP   = 2'd0,
		FIRST = 2'd1, // preamble out, first beat held
		BODY  = 2'd2
	} frm_state_e;

endpackage

`default_nettype wire

// File: source/pcs_xgmii_if.sv
//************************************************************
// XGMII-like word between framer and block encoder
// plain levels sampled every clock, no handshake
// exactly one of idle_v, start, term or a data word per cycle
//************************************************************
`timescale 1ns/100ps
`default_nettype none

interface pcs_xgmii_if;

	logic                         idle_v; // no packet word this cycle
	logic                         start;  // preamble word
	logic                         term;   // last word of the packet
	logic [pcs_pkg::BLOCK_W-1:0] data;
	logic [pcs_pkg::KEEP_W-1:0]  keep;   // valid bytes on term words

	modport frm (
		output idle_v,
		output start,
		output term,
		output data,
		output keep
	);

	modport enc (
		input idle_v,
		input start,
		input term,
		input data,
		input keep
	);

endinterface

`default_nettype wire

// File: source/xgmii_tx_framer.sv
//************************************************************
// packet beats to start, data, terminate and idle words
// each beat leaves one cycle late so the preamble fits in front
// needs two idle cycles after every last beat as there is no ready
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module xgmii_tx_framer (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic                         pkt_valid_i,
	input  logic [pcs_pkg::BLOCK_W-1:0] pkt_data_i,
	input  logic [pcs_pkg::KEEP_W-1:0]  pkt_keep_i,
	input  logic                         pkt_last_i,
	pcs_xgmii_if.frm                     xg
);

	localparam int BLOCK_W = pcs_pkg::BLOCK_W;
	localparam int KEEP_W  = pcs_pkg::KEEP_W;

	pcs_pkg::frm_state_e state_q;
	pcs_pkg::frm_state_e state_next;

	// one beat holding stage
	logic [BLOCK_W-1:0] hold_data;
	logic [KEEP_W-1:0]  hold_keep;
	logic               hold_last;

	logic [BLOCK_W-1:0] shift_data;
	logic [BLOCK_W-1:0] term_data;
	logic [BLOCK_W-1:0] nxt_data;
	logic [KEEP_W-1:0]  nxt_keep;
	logic               nxt_idle;
	logic               nxt_start;
	logic               nxt_term;

	// partial last beat moves up one byte so byte 0 is free for the block type
	always_comb begin
		shift_data = '0;
		for (int b = 1; b < KEEP_W; b++) begin
			if (hold_keep[b-1])
				shift_data[b*8 +: 8] = hold_data[(b-1)*8 +: 8];
		end
	end

	assign term_data = (&hold_keep) ? hold_data : shift_data; // full keep goes as is

	always_comb begin
		state_next = state_q;
		nxt_idle   = 1'b1;
		nxt_start  = 1'b0;
		nxt_term   = 1'b0;
		nxt_data   = hold_data;
		nxt_keep   = hold_keep;
		case (state_q)
			pcs_pkg::GAP: begin
				if (pkt_valid_i) begin
					nxt_idle   = 1'b0;
					nxt_start  = 1'b1;
					nxt_data   = {pcs_pkg::PREAMBLE, 8'h00};
					nxt_keep   = '1;
					state_next = pcs_pkg::FIRST;
				end
			end
			pcs_pkg::FIRST, pcs_pkg::BODY: begin
				nxt_idle = 1'b0;
				nxt_term = hold_last;
				if (hold_last) begin
					nxt_data   = term_data;
					state_next = pcs_pkg::GAP;
				end else begin
					state_next = pcs_pkg::BODY;
				end
			end
			default: state_next = pcs_pkg::GAP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state_q   <= pcs_pkg::GAP;
			hold_last <= 1'b0;
			xg.idle_v <= 1'b1;
			xg.start  <= 1'b0;
			xg.term   <= 1'b0;
		end else begin
			state_q   <= state_next;
			xg.idle_v <= nxt_idle;
			xg.start  <= nxt_start;
			xg.term   <= nxt_term;
			if (pkt_valid_i)
				hold_last <= pkt_last_i;
		end
	end

	always_ff @(posedge clk) begin
		if (pkt_valid_i) begin
			hold_data <= pkt_data_i;
			hold_keep <= pkt_keep_i;
		end
		xg.data <= nxt_data;
		xg.keep <= nxt_keep;
	end

	// preamble slot and a possible extra terminate block both need a free cycle
	a_pkt_gap: assert property (@(posedge clk) disable iff (!nreset)
		pkt_valid_i && pkt_last_i |=> !pkt_valid_i [*2]);

	a_last_keep: assert property (@(posedge clk) disable iff (!nreset)
		pkt_valid_i && pkt_last_i |->
			(pkt_keep_i != '0) && ((pkt_keep_i & (pkt_keep_i + KEEP_W'(1))) == '0));

endmodule

`default_nettype wire

// File: source/pcs_10g_enc_lite.sv
//************************************************************
// 64b/66b block encoder, combinational from the XGMII word
// a full-keep terminate goes out as data and TERM_0 follows
// in the next cycle while the framer sends idle
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module pcs_10g_enc_lite (
	input  logic                         clk,
	input  logic                         nreset,
	pcs_xgmii_if.enc                     xg,
	output logic [1:0]                   head_o,
	output logic [pcs_pkg::BLOCK_W-1:0] data_o
);

	localparam int BLOCK_W = pcs_pkg::BLOCK_W;
	localparam int KEEP_W  = pcs_pkg::KEEP_W;
	localparam int TYPE_W  = pcs_pkg::TYPE_W;

	pcs_pkg::enc_state_e  state_q;
	pcs_pkg::enc_state_e  state_next;
	pcs_pkg::block_type_e block_type;
	pcs_pkg::block_type_e term_type;

	logic                      end_delay;
	logic                      keep_full;
	logic                      last_v;   // this block is a terminate block
	logic                      idle_v;
	logic                      ctrl_v;
	logic [KEEP_W-1:0]         block_keep;
	logic [KEEP_W-1:0]         term_mask;
	logic [BLOCK_W-TYPE_W-1:0] data_ctrl;

	assign end_delay = (state_q == pcs_pkg::END_DELAY);
	assign keep_full = &xg.keep;

	assign last_v = (xg.term & ~keep_full) | end_delay;
	assign idle_v = xg.idle_v & ~end_delay; // the delayed terminate takes the idle slot
	assign ctrl_v = xg.start | last_v | idle_v;

	// contiguous keep plus one gives a onehot of the byte count
	assign block_keep = end_delay ? '0 : xg.keep;
	assign term_mask  = block_keep + KEEP_W'(1);

	always_comb begin
		case (term_mask)
			8'b0000_0001: term_type = pcs_pkg::TERM_0;
			8'b0000_0010: term_type = pcs_pkg::TERM_1;
			8'b0000_0100: term_type = pcs_pkg::TERM_2;
			8'b0000_1000: term_type = pcs_pkg::TERM_3;
			8'b0001_0000: term_type = pcs_pkg::TERM_4;
			8'b0010_0000: term_type = pcs_pkg::TERM_5;
			8'b0100_0000: term_type = pcs_pkg::TERM_6;
			8'b1000_0000: term_type = pcs_pkg::TERM_7;
			default:      term_type = pcs_pkg::CTRL; // not reachable with legal keep
		endcase
	end

	always_comb begin
		if (xg.start)
			block_type = pcs_pkg::START_0;
		else if (last_v)
			block_type = term_type;
		else
			block_type = pcs_pkg::CTRL;
	end

	// bytes 1 to 7 hold idle codes, zeros or the word as the framer built it
	always_comb begin
		if (end_delay)
			data_ctrl = '0;
		else if (idle_v)
			data_ctrl = {8{pcs_pkg::CTRL_IDLE}};
		else
			data_ctrl = xg.data[BLOCK_W-1:TYPE_W];
	end

	assign data_o = {data_ctrl, ctrl_v ? TYPE_W'(block_type) : xg.data[TYPE_W-1:0]};
	assign head_o = ctrl_v ? pcs_pkg::SYNC_CTRL : pcs_pkg::SYNC_DATA;

	always_comb begin
		state_next = state_q;
		case (state_q)
			pcs_pkg::IDLE: begin
				if (xg.start)
					state_next = pcs_pkg::DATA;
			end
			pcs_pkg::DATA: begin
				if (xg.term)
					state_next = keep_full ? pcs_pkg::END_DELAY : pcs_pkg::IDLE;
			end
			pcs_pkg::END_DELAY: state_next = pcs_pkg::IDLE;
			default:            state_next = pcs_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nreset)
			state_q <= pcs_pkg::IDLE;
		else
			state_q <= state_next;
	end

	a_state_onehot: assert property (@(posedge clk) disable iff (!nreset)
		$onehot(state_q));

	// keep matters only on terminate words and data only on packet words
	a_xg_known: assert property (@(posedge clk) disable iff (!nreset)
		!$isunknown({xg.idle_v, xg.start, xg.term}) &&
		(!xg.term || !$isunknown(xg.keep)) &&
		(xg.idle_v || !$isunknown(xg.data)));

endmodule

`default_nettype wire

// File: source/pcs_scrambler.sv
//************************************************************
// self-synchronous scrambler x^58 + x^39 + 1, payload LSB first
// sync header passes unscrambled in the same register stage
// SCRAMBLE = 0 registers the payload unchanged for debug
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module pcs_scrambler #(
	parameter int SCRAMBLE = 1
) (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic [1:0]                   head_i,
	input  logic [pcs_pkg::BLOCK_W-1:0] data_i,
	output logic                         valid_o,
	output logic [1:0]                   head_o,
	output logic [pcs_pkg::BLOCK_W-1:0] data_o
);

	localparam int BLOCK_W = pcs_pkg::BLOCK_W;
	localparam int HIST_W  = 58;
	localparam int TAP     = 39;

	logic [HIST_W-1:0]  hist_q;   // bit 0 is the newest scrambled bit
	logic [HIST_W-1:0]  hist_next;
	logic [BLOCK_W-1:0] scr_data;

	always_comb begin
		hist_next = hist_q;
		for (int i = 0; i < BLOCK_W; i++) begin
			scr_data[i] = data_i[i] ^ hist_next[TAP-1] ^ hist_next[HIST_W-1];
			hist_next   = {hist_next[HIST_W-2:0], scr_data[i]};
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			hist_q  <= '1;
			valid_o <= 1'b0;
		end else begin
			hist_q  <= hist_next;
			valid_o <= 1'b1; // one block every cycle
		end
	end

	always_ff @(posedge clk) begin
		head_o <= head_i;
		data_o <= (SCRAMBLE != 0) ? scr_data : data_i;
	end

	// header comes from the encoder a stage earlier
	a_head_legal: assert property (@(posedge clk)
		valid_o |-> (head_o == pcs_pkg::SYNC_DATA) || (head_o == pcs_pkg::SYNC_CTRL));

endmodule

`default_nettype wire

// File: source/pcs_tx.sv
//************************************************************
// 10GBASE-R style transmit PCS slice, 64-bit datapath
// start block leaves 2 cycles after the first beat
// source keeps two idle cycles after each last beat
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module pcs_tx #(
	parameter int SCRAMBLE = 1 // 0 bypasses the scrambler
) (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic                         pkt_valid_i,
	input  logic [pcs_pkg::BLOCK_W-1:0] pkt_data_i,
	input  logic [pcs_pkg::KEEP_W-1:0]  pkt_keep_i,
	input  logic                         pkt_last_i,
	output logic                         blk_valid_o,
	output logic [1:0]                   blk_head_o,
	output logic [pcs_pkg::BLOCK_W-1:0] blk_data_o
);

	logic [1:0]                   enc_head;
	logic [pcs_pkg::BLOCK_W-1:0] enc_data;

	pcs_xgmii_if xg_if ();

	xgmii_tx_framer i_framer (
		.clk         (clk),
		.nreset      (nreset),
		.pkt_valid_i (pkt_valid_i),
		.pkt_data_i  (pkt_data_i),
		.pkt_keep_i  (pkt_keep_i),
		.pkt_last_i  (pkt_last_i),
		.xg          (xg_if.frm)
	);

	pcs_10g_enc_lite i_enc (
		.clk    (clk),
		.nreset (nreset),
		.xg     (xg_if.enc),
		.head_o (enc_head),
		.data_o (enc_data)
	);

	pcs_scrambler #(
		.SCRAMBLE (SCRAMBLE)
	) i_scrambler (
		.clk     (clk),
		.nreset  (nreset),
		.head_i  (enc_head),
		.data_i  (enc_data),
		.valid_o (blk_valid_o),
		.head_o  (blk_head_o),
		.data_o  (blk_data_o)
	);

endmodule

`default_nettype wire

// File: tb/pcs_tx_ref.svh
//************************************************************
// reference model of the transmit PCS testbench
// descrambler is only in sync from the second block on
// expected blocks hold the payload before scrambling
//************************************************************
`ifndef PCS_TX_REF_SVH
`define PCS_TX_REF_SVH

logic [63:0] rng_state = 64'd61;
logic [57:0] dsc_hist  = '0; // bit 0 is the newest received bit
logic [1:0]  exp_head[$];
logic [63:0] exp_data[$];

pcs_pkg::block_type_e term_types [8] = '{pcs_pkg::TERM_0, pcs_pkg::TERM_1, pcs_pkg::TERM_2,
	pcs_pkg::TERM_3, pcs_pkg::TERM_4, pcs_pkg::TERM_5, pcs_pkg::TERM_6, pcs_pkg::TERM_7};

function automatic logic [63:0] xorshift64();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 7;
	rng_state ^= rng_state << 17;
	return rng_state;
endfunction

// x^58 + x^39 + 1, fed with the received bits LSB first
function automatic logic [63:0] descramble(input logic [63:0] s);
	logic [63:0] d;
	for (int i = 0; i < 64; i++) begin
		d[i]     = s[i] ^ dsc_hist[38] ^ dsc_hist[57];
		dsc_hist = {dsc_hist[56:0], s[i]};
	end
	return d;
endfunction

function automatic logic [7:0] keep_for(input int n);
	logic [7:0] keep;
	keep = '0;
	for (int b = 0; b < n; b++)
		keep[b] = 1'b1;
	return keep;
endfunction

// bytes 1 to k of a terminate block, seen from the payload side
function automatic logic [55:0] term_payload(input logic [63:0] d, input int k);
	logic [55:0] p;
	p = '0;
	for (int b = 0; b < k; b++)
		p[b*8 +: 8] = d[b*8 +: 8];
	return p;
endfunction

function automatic void expect_ctrl(input pcs_pkg::block_type_e t, input logic [55:0] payload);
	exp_head.push_back(pcs_pkg::SYNC_CTRL);
	exp_data.push_back({payload, t});
endfunction

function automatic void expect_data(input logic [63:0] d);
	exp_head.push_back(pcs_pkg::SYNC_DATA);
	exp_data.push_back(d);
endfunction

`endif

// File: tb/pcs_tx_tb.sv
//************************************************************
// directed testbench for the transmit PCS slice
// compares descrambled payloads so SCRAMBLE must stay at 1
// sources keep exactly two idle cycles between packets
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_tb;

	localparam logic [55:0] IDLE_PAYLOAD = {8{pcs_pkg::CTRL_IDLE}};

	logic        clk;
	logic        nreset;
	logic        pkt_valid_i;
	logic [63:0] pkt_data_i;
	logic [7:0]  pkt_keep_i;
	logic        pkt_last_i;
	logic        blk_valid_o;
	logic [1:0]  blk_head_o;
	logic [63:0] blk_data_o;

	int          cyc       = 0; // posedges so far
	int          nblk      = 0;
	int          idle_cnt  = 0;
	int          start_cyc = 0; // stamp of the latest start block
	logic        in_pkt    = 1'b0;
	logic        rst_done  = 1'b0;
	logic [63:0] last_raw;

	`include "pcs_tx_ref.svh"

	pcs_tx i_pcs_tx (
		.clk         (clk),
		.nreset      (nreset),
		.pkt_valid_i (pkt_valid_i),
		.pkt_data_i  (pkt_data_i),
		.pkt_keep_i  (pkt_keep_i),
		.pkt_last_i  (pkt_last_i),
		.blk_valid_o (blk_valid_o),
		.blk_head_o  (blk_head_o),
		.blk_data_o  (blk_data_o)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_head(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_type(input string name, input pcs_pkg::block_type_e got,
			input pcs_pkg::block_type_e exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_payload(input string name, input logic [55:0] got,
			input logic [55:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp));
	endtask

	// idle blocks pass between packets and anything else must be next in the queue
	task automatic take_block(input logic [1:0] head, input logic [63:0] plain, input int stamp);
		pcs_pkg::block_type_e got_type;
		pcs_pkg::block_type_e exp_type;
		logic [1:0]           eh;
		logic [63:0]          ed;
		got_type = pcs_pkg::block_type_e'(plain[7:0]);
		nblk++;
		if (nblk == 1)
			return; // descrambler history still filling
		if (!in_pkt && head == pcs_pkg::SYNC_CTRL && got_type == pcs_pkg::CTRL) begin
			check_payload("idle payload", plain[63:8], IDLE_PAYLOAD);
			idle_cnt++;
		end else if (exp_head.size() == 0) begin
			abort_run("a packet block came out while no packet was pending");
		end else begin
			eh       = exp_head.pop_front();
			ed       = exp_data.pop_front();
			exp_type = pcs_pkg::block_type_e'(ed[7:0]);
			check_head("blk_head_o", head, eh);
			if (eh == pcs_pkg::SYNC_DATA) begin
				check_data("data block", plain, ed);
			end else begin
				check_type("block type", got_type, exp_type);
				check_payload("control payload", plain[63:8], ed[63:8]);
				in_pkt = (exp_type == pcs_pkg::START_0); // other control blocks end it
				if (in_pkt)
					start_cyc = stamp;
			end
		end
	endtask

	// outputs read before this edge updates them
	always @(posedge clk) begin
		if (rst_done)
			check_valid("blk_valid_o", blk_valid_o, 1'b1);
		if (blk_valid_o === 1'b1) begin
			last_raw = blk_data_o;
			take_block(blk_head_o, descramble(blk_data_o), cyc);
		end
		cyc++;
	end

	task automatic send_packet(input int nbeats, input int nlast, output int t0);
		logic [63:0] d;
		for (int i = 0; i < nbeats; i++) begin
			@(negedge clk);
			d = xorshift64(); // bytes above the keep stay random
			if (i == 0) begin
				t0 = cyc;
				expect_ctrl(pcs_pkg::START_0, pcs_pkg::PREAMBLE);
			end
			pkt_valid_i = 1'b1;
			pkt_data_i  = d;
			pkt_keep_i  = (i == nbeats - 1) ? keep_for(nlast) : 8'hff;
			pkt_last_i  = (i == nbeats - 1);
			if (i < nbeats - 1 || nlast == 8)
				expect_data(d);
			if (i == nbeats - 1)
				expect_ctrl(term_types[3'(nlast)], term_payload(d, nlast % 8));
		end
		@(negedge clk);
		pkt_valid_i = 1'b0;
		pkt_keep_i  = '0;
		pkt_last_i  = 1'b0;
		@(negedge clk); // second gap cycle
	endtask

	// returns after the pending blocks and then count idle blocks came out
	task automatic wait_idle(input int count);
		int n;
		int target;
		n      = 0;
		target = idle_cnt + count;
		while (exp_head.size() != 0 || in_pkt || idle_cnt < target) begin
			@(negedge clk);
			n++;
			if (exp_head.size() != 0 || in_pkt)
				target = idle_cnt + count;
			if (n > 200)
				abort_run("timeout while waiting for packet blocks and idle blocks");
		end
	endtask

	task automatic reset_and_idle();
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_valid("blk_valid_o", blk_valid_o, 1'b0);
		end
		nreset = 1'b1;
		@(negedge clk);
		check_valid("blk_valid_o", blk_valid_o, 1'b1);
		rst_done = 1'b1;
		wait_idle(8);
	endtask

	task automatic short_packet();
		int t0;
		send_packet(2, 3, t0);
		wait_idle(2);
		if (start_cyc != t0 + 2)
			abort_run($sformatf("start block came %0d cycles after the first beat, not 2",
				start_cyc - t0));
	endtask

	task automatic full_keep_packet();
		int t0;
		send_packet(3, 8, t0);
		wait_idle(2);
	endtask

	task automatic keep_sweep();
		int t0;
		for (int k = 1; k <= 8; k++) begin
			send_packet(1 + int'(xorshift64() % 64'd6), k, t0);
			wait_idle(1);
		end
	endtask

	task automatic back_to_back();
		int t0;
		send_packet(3, 8, t0);
		send_packet(2, 5, t0);
		send_packet(1, 8, t0);
		send_packet(4, 1, t0);
		send_packet(1, 3, t0);
		wait_idle(2);
	endtask

	task automatic scrambled_idle();
		for (int i = 0; i < 8; i++) begin
			wait_idle(1);
			if (last_raw == {IDLE_PAYLOAD, pcs_pkg::CTRL})
				abort_run("an idle block left the scrambler unchanged");
		end
	endtask

	initial begin
		clk         = 1'b0;
		nreset      = 1'b0;
		pkt_valid_i = 1'b0;
		pkt_data_i  = '0;
		pkt_keep_i  = '0;
		pkt_last_i  = 1'b0;
		reset_and_idle();
		short_packet();
		full_keep_packet();
		keep_sweep();
		back_to_back();
		scrambled_idle();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: pcs_tx.f
+incdir+tb
source/pcs_pkg.sv
source/pcs_xgmii_if.sv
source/xgmii_tx_framer.sv
source/pcs_10g_enc_lite.sv
source/pcs_scrambler.sv
source/pcs_tx.sv
tb/pcs_tx_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module pcs_tx_tb -f pcs_tx.f -o pcs_tx_sim
	@out="$$(./obj_dir/pcs_tx_sim)"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
